//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// --------------------
	// Basic types
	// --------------------
	typedef logic [15:0] word_t;   // Data word and byte address
	typedef logic [3:0] reg_idx_t; // r0 reads as zero

	// Z in bit 2, V in bit 1, N in bit 0
	typedef logic [2:0] flags_t;

	localparam int FLAG_Z = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 0;

	// --------------------
	// Opcodes in bits 15:12
	// --------------------
	typedef enum logic [3:0] {
		OP_ADD = 4'h0, // Saturating
		OP_SUB = 4'h1, // Saturating
		OP_XOR = 4'h2,
		OP_AND = 4'h3,
		OP_SLL = 4'h4, // Shift amount is imm4
		OP_SRA = 4'h5,
		OP_ROR = 4'h6,
		OP_OR  = 4'h7,
		OP_LW  = 4'h8,
		OP_SW  = 4'h9,
		OP_LHB = 4'hA, // Replace high byte
		OP_LLB = 4'hB, // Replace low byte
		OP_B   = 4'hC, // PC relative, conditional
		OP_BR  = 4'hD, // Register target, conditional
		OP_PCS = 4'hE, // rd gets PC+2
		OP_HLT = 4'hF
	} opcode_t;

	// Branch conditions in bits 11:9
	localparam logic [2:0] COND_NE = 3'b000; // Z clear
	localparam logic [2:0] COND_EQ = 3'b001; // Z set
	localparam logic [2:0] COND_GT = 3'b010; // Z and N clear
	localparam logic [2:0] COND_LT = 3'b011; // N set
	localparam logic [2:0] COND_GE = 3'b100;
	localparam logic [2:0] COND_LE = 3'b101;
	localparam logic [2:0] COND_OV = 3'b110; // V set
	localparam logic [2:0] COND_UN = 3'b111; // Always

	// Operand source seen by the EX stage
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0, // Value read in ID
		FWD_MEM  = 2'd1, // EX/MEM result
		FWD_WB   = 2'd2  // MEM/WB result
	} fwd_sel_t;

	// --------------------
	// Memory and fetch
	// --------------------
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW = $clog2(DMEM_WORDS); // Word index is addr[8:1]

	localparam word_t PC_STEP = 16'd2; // Bytes per instruction

	// ADD r0, r0, r0 is the pipeline bubble
	localparam word_t NOP_INSTR = 16'h0000;

endpackage

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  logic           clk,
	input  logic           reset,
	input  logic           stall,         // Load-use hold from ID
	input  logic           hlt_stop,      // HLT seen in ID
	input  logic           branch_taken,  // Redirect from EX
	input  cpu_pkg::word_t branch_target,
	input  cpu_pkg::word_t imem_data,     // Instruction at pc, same cycle
	output cpu_pkg::word_t pc,
	output cpu_pkg::word_t id_pc,         // PC+2 of the word in ID
	output cpu_pkg::word_t id_instr
);
	import cpu_pkg::*;

	word_t pc_plus2;

	assign pc_plus2 = pc + PC_STEP;

	// Branch redirect wins over both holds
	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else if (branch_taken)
			pc <= branch_target;
		else if (!stall && !hlt_stop)
			pc <= pc_plus2;
	end

	// --------------------
	// IF/ID register
	// --------------------
	always_ff @(posedge clk) begin
		if (reset || branch_taken || hlt_stop)
			id_instr <= NOP_INSTR; // Squash the younger word
		else if (!stall)
			id_instr <= imem_data;
	end

	always_ff @(posedge clk)
		if (!stall)
			id_pc <= pc_plus2; // Return address and branch base

endmodule

`default_nettype wire

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::word_t    id_pc,
	input  cpu_pkg::word_t    id_instr,
	input  logic              branch_taken, // Flush from EX
	input  logic              wb_en,
	input  cpu_pkg::reg_idx_t wb_reg,
	input  cpu_pkg::word_t    wb_data,
	output logic              stall,
	output logic              hlt_stop,
	output cpu_pkg::word_t    ex_pc,
	output cpu_pkg::word_t    ex_instr,
	output cpu_pkg::word_t    ex_rs_data,   // First source value
	output cpu_pkg::word_t    ex_rt_data,   // Second source value
	output cpu_pkg::reg_idx_t ex_rs,
	output cpu_pkg::reg_idx_t ex_rt,
	output cpu_pkg::reg_idx_t ex_rd,
	output logic              ex_reg_write,
	output logic              ex_mem_read,
	output logic              ex_mem_write
);
	import cpu_pkg::*;

	opcode_t  op;
	reg_idx_t rd, src1, src2;
	logic     use_src1, use_src2, writes_reg;
	word_t    regs [16];
	word_t    src1_data, src2_data;
	logic     halted; // Sticky once HLT leaves ID

	assign op = opcode_t'(id_instr[15:12]);
	assign rd = id_instr[11:8];

	// --------------------
	// Control decode
	// --------------------
	always_comb begin
		use_src1 = 1'b0;
		use_src2 = 1'b0;
		writes_reg = 1'b0;
		case (op)
			OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_OR: begin
				use_src1 = 1'b1; // rs
				use_src2 = 1'b1; // rt
				writes_reg = 1'b1;
			end
			OP_SLL, OP_SRA, OP_ROR, OP_LHB, OP_LLB: begin
				use_src1 = 1'b1; // Low nibble is imm4 or part of imm8
				writes_reg = 1'b1;
			end
			OP_LW: begin
				use_src2 = 1'b1; // Base register
				writes_reg = 1'b1;
			end
			OP_SW: begin
				use_src1 = 1'b1; // Store data from rd
				use_src2 = 1'b1; // Base register
			end
			OP_BR:  use_src1 = 1'b1;
			OP_PCS: writes_reg = 1'b1;
			default: ; // B and HLT read nothing
		endcase
	end

	// Unused sources collapse to r0 so hazards and forwarding skip them
	assign src1 = !use_src1 ? '0 :
		(op == OP_SW || op == OP_LHB || op == OP_LLB) ? id_instr[11:8] : id_instr[7:4];
	assign src2 = !use_src2 ? '0 :
		(op == OP_SW || op == OP_LW) ? id_instr[7:4] : id_instr[3:0];

	// --------------------
	// Register file
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wb_en && wb_reg != '0) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// Write in the same cycle is passed straight through
	assign src1_data = (src1 == '0) ? '0 :
		(wb_en && wb_reg == src1) ? wb_data : regs[src1];
	assign src2_data = (src2 == '0) ? '0 :
		(wb_en && wb_reg == src2) ? wb_data : regs[src2];

	// Load in EX feeding this instruction costs one bubble
	assign stall = ex_mem_read && ex_rd != '0 && (ex_rd == src1 || ex_rd == src2);

	// A flushed HLT must not freeze fetch
	assign hlt_stop = halted || (op == OP_HLT && !branch_taken);

	always_ff @(posedge clk) begin
		if (reset)
			halted <= 1'b0;
		else if (op == OP_HLT && !branch_taken)
			halted <= 1'b1;
	end

	// --------------------
	// ID/EX register
	// --------------------
	always_ff @(posedge clk) begin
		if (reset || branch_taken || stall) begin
			ex_instr <= NOP_INSTR; // Bubble
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
		end else begin
			ex_instr <= id_instr;
			ex_reg_write <= writes_reg && rd != '0; // r0 writes are dropped
			ex_mem_read <= (op == OP_LW);
			ex_mem_write <= (op == OP_SW);
		end
	end

	always_ff @(posedge clk) begin
		ex_pc <= id_pc;
		ex_rs_data <= src1_data;
		ex_rt_data <= src2_data;
		ex_rs <= src1;
		ex_rt <= src2;
		ex_rd <= rd;
	end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::word_t    ex_pc,         // Already PC+2
	input  cpu_pkg::word_t    ex_instr,
	input  cpu_pkg::word_t    ex_rs_data,
	input  cpu_pkg::word_t    ex_rt_data,
	input  cpu_pkg::reg_idx_t ex_rs,
	input  cpu_pkg::reg_idx_t ex_rt,
	input  cpu_pkg::reg_idx_t ex_rd,
	input  logic              ex_reg_write,
	input  logic              ex_mem_read,
	input  logic              ex_mem_write,
	input  logic              mem_reg_write, // EX/MEM fed back
	input  cpu_pkg::reg_idx_t mem_rd,
	input  cpu_pkg::word_t    mem_result,    // Final MEM value, load data included
	input  logic              wb_en,         // MEM/WB fed back
	input  cpu_pkg::reg_idx_t wb_reg,
	input  cpu_pkg::word_t    wb_data,
	output logic              branch_taken,
	output cpu_pkg::word_t    branch_target,
	output logic              mem_reg_write_o,
	output cpu_pkg::reg_idx_t mem_rd_o,
	output cpu_pkg::word_t    mem_alu_result,
	output cpu_pkg::word_t    mem_addr,
	output cpu_pkg::word_t    mem_store_data,
	output logic              mem_read_o,
	output logic              mem_write_o,
	output logic              mem_halt_o     // HLT marker toward MEM/WB
);
	import cpu_pkg::*;

	opcode_t     op;
	fwd_sel_t    fwd1, fwd2;
	word_t       opa, opb;
	word_t       sum, diff, result, addr;
	logic        ovf, cond_met;
	logic [31:0] rot;
	logic [3:0]  shamt;
	logic [7:0]  imm8;
	flags_t      flags, flags_next;

	assign op = opcode_t'(ex_instr[15:12]);
	assign shamt = ex_instr[3:0];
	assign imm8 = ex_instr[7:0];

	// --------------------
	// Forwarding
	// --------------------
	always_comb begin
		fwd1 = FWD_NONE;
		fwd2 = FWD_NONE;
		if (ex_rs != '0 && mem_reg_write && mem_rd == ex_rs)
			fwd1 = FWD_MEM; // Youngest value wins
		else if (ex_rs != '0 && wb_en && wb_reg == ex_rs)
			fwd1 = FWD_WB;
		if (ex_rt != '0 && mem_reg_write && mem_rd == ex_rt)
			fwd2 = FWD_MEM;
		else if (ex_rt != '0 && wb_en && wb_reg == ex_rt)
			fwd2 = FWD_WB;
	end

	assign opa = (fwd1 == FWD_MEM) ? mem_result : (fwd1 == FWD_WB) ? wb_data : ex_rs_data;
	assign opb = (fwd2 == FWD_MEM) ? mem_result : (fwd2 == FWD_WB) ? wb_data : ex_rt_data;

	// --------------------
	// ALU and result select
	// --------------------
	assign sum = opa + opb;
	assign diff = opa - opb;
	assign rot = {opa, opa} >> shamt; // Rotate via doubled word

	always_comb begin
		ovf = 1'b0;
		case (op)
			OP_ADD: begin
				ovf = (opa[15] == opb[15]) && (sum[15] != opa[15]);
				result = !ovf ? sum : opa[15] ? 16'h8000 : 16'h7FFF; // Clamp
			end
			OP_SUB: begin
				ovf = (opa[15] != opb[15]) && (diff[15] != opa[15]);
				result = !ovf ? diff : opa[15] ? 16'h8000 : 16'h7FFF;
			end
			OP_XOR: result = opa ^ opb;
			OP_AND: result = opa & opb;
			OP_OR:  result = opa | opb;
			OP_SLL: result = opa << shamt;
			OP_SRA: result = word_t'($signed(opa) >>> shamt);
			OP_ROR: result = rot[15:0];
			OP_LHB: result = {imm8, opa[7:0]}; // opa holds old rd
			OP_LLB: result = {opa[15:8], imm8};
			OP_PCS: result = ex_pc;
			default: result = '0;
		endcase
	end

	// Bubbles carry no register write, so they leave flags alone
	always_comb begin
		flags_next = flags;
		if (ex_reg_write) begin
			case (op)
				OP_ADD, OP_SUB: begin
					flags_next[FLAG_Z] = (result == '0);
					flags_next[FLAG_V] = ovf;
					flags_next[FLAG_N] = result[15];
				end
				OP_XOR, OP_AND, OP_OR, OP_SLL, OP_SRA, OP_ROR:
					flags_next[FLAG_Z] = (result == '0); // Z only
				default: ;
			endcase
		end
	end

	// --------------------
	// Branch resolve
	// --------------------
	always_comb begin
		case (ex_instr[11:9])
			COND_NE: cond_met = !flags[FLAG_Z];
			COND_EQ: cond_met = flags[FLAG_Z];
			COND_GT: cond_met = !flags[FLAG_Z] && !flags[FLAG_N];
			COND_LT: cond_met = flags[FLAG_N];
			COND_GE: cond_met = flags[FLAG_Z] || !flags[FLAG_N];
			COND_LE: cond_met = flags[FLAG_Z] || flags[FLAG_N];
			COND_OV: cond_met = flags[FLAG_V];
			default: cond_met = 1'b1; // Unconditional
		endcase
	end

	assign branch_taken = (op == OP_B || op == OP_BR) && cond_met;
	assign branch_target = (op == OP_BR) ? opa :
		ex_pc + {{6{ex_instr[8]}}, ex_instr[8:0], 1'b0}; // PC+2 plus 2*imm9

	// Word aligned base plus signed word offset
	assign addr = (opb & 16'hFFFE) + {{11{ex_instr[3]}}, ex_instr[3:0], 1'b0};

	// --------------------
	// EX/MEM register
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
			mem_reg_write_o <= 1'b0;
			mem_read_o <= 1'b0;
			mem_write_o <= 1'b0;
			mem_halt_o <= 1'b0;
		end else begin
			flags <= flags_next;
			mem_reg_write_o <= ex_reg_write;
			mem_read_o <= ex_mem_read;
			mem_write_o <= ex_mem_write;
			mem_halt_o <= (op == OP_HLT);
		end
	end

	always_ff @(posedge clk) begin
		mem_rd_o <= ex_rd;
		mem_alu_result <= result;
		mem_addr <= addr;
		mem_store_data <= opa; // rd value for SW
	end

endmodule

`default_nettype wire

//--- memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              mem_reg_write,
	input  cpu_pkg::reg_idx_t mem_rd,
	input  cpu_pkg::word_t    mem_alu_result,
	input  cpu_pkg::word_t    mem_addr,       // Byte address, bit 0 ignored
	input  cpu_pkg::word_t    mem_store_data,
	input  logic              mem_read,
	input  logic              mem_write,
	input  logic              mem_halt,
	output cpu_pkg::word_t    mem_result,     // Also the MEM forwarding source
	output logic              wb_en,
	output cpu_pkg::reg_idx_t wb_reg,
	output cpu_pkg::word_t    wb_data,
	output logic              hlt
);
	import cpu_pkg::*;

	word_t                dmem [DMEM_WORDS];
	logic [DMEM_AW-1:0]   word_idx;

	assign word_idx = mem_addr[DMEM_AW:1];

	// --------------------
	// Data memory
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else if (mem_write) begin
			dmem[word_idx] <= mem_store_data;
		end
	end

	// Combinational read
	assign mem_result = mem_read ? dmem[word_idx] : mem_alu_result;

	// --------------------
	// MEM/WB register
	// --------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_en <= 1'b0;
			hlt <= 1'b0;
		end else begin
			wb_en <= mem_reg_write; // One pulse per retiring write
			hlt <= hlt | mem_halt;  // Older work has already drained
		end
	end

	always_ff @(posedge clk) begin
		wb_reg <= mem_rd;
		wb_data <= mem_result;
	end

endmodule

`default_nettype wire

//--- cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::word_t    imem_data, // Instruction at pc
	output cpu_pkg::word_t    pc,
	output logic              wb_valid,  // Register write strobe
	output cpu_pkg::reg_idx_t wb_reg,
	output cpu_pkg::word_t    wb_data,
	output logic              hlt
);
	import cpu_pkg::*;

	// --------------------
	// Stage to stage nets
	// --------------------
	logic     stall, hlt_stop;
	logic     branch_taken;
	word_t    branch_target;

	word_t    id_pc, id_instr;

	word_t    ex_pc, ex_instr, ex_rs_data, ex_rt_data;
	reg_idx_t ex_rs, ex_rt, ex_rd;
	logic     ex_reg_write, ex_mem_read, ex_mem_write;

	logic     mem_reg_write, mem_read, mem_write, mem_halt;
	reg_idx_t mem_rd;
	word_t    mem_alu_result, mem_addr, mem_store_data, mem_result;

	fetch_stage u_fetch (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.hlt_stop(hlt_stop),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.imem_data(imem_data),
		.pc(pc),
		.id_pc(id_pc),
		.id_instr(id_instr)
	);

	// Register file write comes from MEM/WB
	decode_stage u_decode (
		.clk(clk),
		.reset(reset),
		.id_pc(id_pc),
		.id_instr(id_instr),
		.branch_taken(branch_taken),
		.wb_en(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.stall(stall),
		.hlt_stop(hlt_stop),
		.ex_pc(ex_pc),
		.ex_instr(ex_instr),
		.ex_rs_data(ex_rs_data),
		.ex_rt_data(ex_rt_data),
		.ex_rs(ex_rs),
		.ex_rt(ex_rt),
		.ex_rd(ex_rd),
		.ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write)
	);

	execute_stage u_execute (
		.clk(clk),
		.reset(reset),
		.ex_pc(ex_pc),
		.ex_instr(ex_instr),
		.ex_rs_data(ex_rs_data),
		.ex_rt_data(ex_rt_data),
		.ex_rs(ex_rs),
		.ex_rt(ex_rt),
		.ex_rd(ex_rd),
		.ex_reg_write(ex_reg_write),
		.ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write),
		.mem_reg_write(mem_reg_write), // Forward path from MEM
		.mem_rd(mem_rd),
		.mem_result(mem_result),
		.wb_en(wb_valid),              // Forward path from WB
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.mem_reg_write_o(mem_reg_write),
		.mem_rd_o(mem_rd),
		.mem_alu_result(mem_alu_result),
		.mem_addr(mem_addr),
		.mem_store_data(mem_store_data),
		.mem_read_o(mem_read),
		.mem_write_o(mem_write),
		.mem_halt_o(mem_halt)
	);

	memory_stage u_memory (
		.clk(clk),
		.reset(reset),
		.mem_reg_write(mem_reg_write),
		.mem_rd(mem_rd),
		.mem_alu_result(mem_alu_result),
		.mem_addr(mem_addr),
		.mem_store_data(mem_store_data),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_halt(mem_halt),
		.mem_result(mem_result),
		.wb_en(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.hlt(hlt)
	);

endmodule

`default_nettype wire

//--- cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
	input logic              clk,
	input logic              reset,
	input cpu_pkg::word_t    pc,
	input logic              stall,
	input logic              wb_valid,
	input cpu_pkg::reg_idx_t wb_reg,
	input cpu_pkg::word_t    wb_data,
	input logic              hlt
);
	int unsigned fail_count = 0; // Read by the testbench summary

	// r0 is hardwired, so a write report for it must carry zero
	r0_write_zero: assert property (@(posedge clk) disable iff (reset)
		!(wb_valid && wb_reg == '0 && wb_data != '0))
	else begin
		fail_count++;
		$error("write report for r0 carries nonzero data");
	end

	// --------------------
	// Fetch holds
	// --------------------
	stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
		stall |=> $stable(pc))
	else begin
		fail_count++;
		$error("pc moved during a load-use stall");
	end

	halt_freezes_pc: assert property (@(posedge clk) disable iff (reset)
		hlt |=> $stable(pc))
	else begin
		fail_count++;
		$error("pc moved after halt");
	end

	halt_no_writes: assert property (@(posedge clk) disable iff (reset)
		hlt |-> !wb_valid)
	else begin
		fail_count++;
		$error("register write reported after halt");
	end

	// One edge of reset is enough to clear the outputs
	reset_clears: assert property (@(posedge clk)
		reset |=> !wb_valid && !hlt)
	else begin
		fail_count++;
		$error("wb_valid or hlt still high after reset");
	end

endmodule

`default_nettype wire

//--- cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
	import cpu_pkg::*;

	localparam int NUM_TESTS = 5;
	localparam int CLK_PERIOD = 8;

	logic     clk = 1'b0;
	logic     reset = 1'b1;
	word_t    imem_data = NOP_INSTR;
	word_t    pc, wb_data;
	reg_idx_t wb_reg;
	logic     wb_valid, hlt;

	word_t    imem [256];        // Instruction memory, word index pc[8:1]
	int       prog_len;
	reg_idx_t exp_reg[$], obs_reg[$];
	word_t    exp_data[$], obs_data[$];
	int       errors = 0;

	cpu uut (
		.clk(clk),
		.reset(reset),
		.imem_data(imem_data),
		.pc(pc),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.hlt(hlt)
	);

	bind cpu cpu_checker u_checker (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.stall(stall),          // Internal load-use stall
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.hlt(hlt)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Instruction word follows pc one step after the edge
	always @(posedge clk) begin
		#1;
		imem_data = imem[pc[8:1]];
	end

	// Collect every retiring write at mid cycle
	always @(negedge clk) begin
		if (wb_valid) begin
			obs_reg.push_back(wb_reg);
			obs_data.push_back(wb_data);
		end
	end

	// --------------------
	// Instruction encoders
	// --------------------
	function automatic word_t encode_rrr(opcode_t op, int rd, int rs, int rt);
		return {op, rd[3:0], rs[3:0], rt[3:0]}; // rt doubles as imm4
	endfunction

	function automatic word_t encode_imm8(opcode_t op, int rd, int imm);
		return {op, rd[3:0], imm[7:0]};
	endfunction

	function automatic word_t encode_b(logic [2:0] cond, int offset);
		return {OP_B, cond, offset[8:0]}; // Offset in instructions
	endfunction

	function automatic word_t encode_br(logic [2:0] cond, int rs);
		return {OP_BR, cond, 1'b0, rs[3:0], 4'h0};
	endfunction

	task automatic begin_program();
		for (int i = 0; i < 256; i++)
			imem[i] = {OP_HLT, 4'h0, i[7:0]}; // Stray fetches stop the core
		prog_len = 0;
		exp_reg.delete();
		exp_data.delete();
	endtask

	task automatic add_instr(word_t instr);
		imem[prog_len] = instr;
		prog_len++;
	endtask

	task automatic expect_write(int rd, int value);
		exp_reg.push_back(rd[3:0]);
		exp_data.push_back(value[15:0]);
	endtask

	// --------------------
	// Compare tasks
	// --------------------
	task automatic check_reg(string name, string ctx, reg_idx_t got, reg_idx_t exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s (%s) got 0x%h expected 0x%h", name, ctx, got, exp);
		end
	endtask

	task automatic check_word(string name, string ctx, word_t got, word_t exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s (%s) got 0x%h expected 0x%h", name, ctx, got, exp);
		end
	endtask

	// Reset, run to halt, then compare the write list in order
	task automatic run_and_compare(string test);
		int n_at_hlt;
		int n;
		@(posedge clk);
		#1 reset = 1'b1;
		repeat (10) @(posedge clk);
		obs_reg.delete();
		obs_data.delete();
		#1 reset = 1'b0;
		check_word("pc", $sformatf("%s after reset", test), pc, 16'h0000); // First cycle at zero
		while (hlt !== 1'b1)
			@(negedge clk);
		n_at_hlt = obs_reg.size();
		repeat (8) @(negedge clk); // Anything still in flight shows up here
		if (n_at_hlt != exp_reg.size()) begin
			errors++;
			$display("%s: %0d writes retired before halt, expected %0d",
				test, n_at_hlt, exp_reg.size());
		end
		if (obs_reg.size() != n_at_hlt) begin
			errors++;
			$display("%s: register writes kept coming after halt", test);
		end
		n = (obs_reg.size() < exp_reg.size()) ? obs_reg.size() : exp_reg.size();
		for (int i = 0; i < n; i++) begin
			check_reg("wb_reg", $sformatf("%s write %0d", test, i), obs_reg[i], exp_reg[i]);
			check_word("wb_data", $sformatf("%s write %0d", test, i), obs_data[i], exp_data[i]);
		end
	endtask

	// --------------------
	// Directed tests
	// --------------------
	task automatic test_alu_forwarding();
		begin_program();
		add_instr(encode_imm8(OP_LLB, 1, 'h34));
		expect_write(1, 'h0034);
		add_instr(encode_imm8(OP_LHB, 1, 'h12)); // Old low byte from MEM
		expect_write(1, 'h1234);
		add_instr(encode_imm8(OP_LLB, 2, 'hFF));
		expect_write(2, 'h00FF);
		add_instr(encode_imm8(OP_LHB, 2, 'h7F));
		expect_write(2, 'h7FFF);
		add_instr(encode_rrr(OP_ADD, 3, 1, 2)); // Positive overflow clamps
		expect_write(3, 'h7FFF);
		add_instr(encode_rrr(OP_SUB, 4, 2, 3)); // r3 from MEM, r2 from WB
		expect_write(4, 'h0000);
		add_instr(encode_imm8(OP_LHB, 5, 'h80));
		expect_write(5, 'h8000);
		add_instr(encode_rrr(OP_SUB, 6, 5, 2)); // Negative overflow clamps
		expect_write(6, 'h8000);
		add_instr(encode_rrr(OP_XOR, 7, 1, 6));
		expect_write(7, 'h9234);
		add_instr(encode_rrr(OP_AND, 8, 7, 1));
		expect_write(8, 'h1234);
		add_instr(encode_rrr(OP_OR, 9, 8, 7));
		expect_write(9, 'h9234);
		add_instr(encode_rrr(OP_ADD, 10, 9, 1)); // Mixed signs never clamp
		expect_write(10, 'hA468);
		add_instr({OP_HLT, 12'h000});
		run_and_compare("alu");
	endtask

	task automatic test_shifts();
		begin_program();
		add_instr(encode_imm8(OP_LLB, 1, 'hF0));
		expect_write(1, 'h00F0);
		add_instr(encode_imm8(OP_LHB, 1, 'h96));
		expect_write(1, 'h96F0);
		add_instr(encode_rrr(OP_SLL, 2, 1, 4));
		expect_write(2, 'h6F00);
		add_instr(encode_rrr(OP_SLL, 3, 1, 0));
		expect_write(3, 'h96F0);
		add_instr(encode_rrr(OP_SRA, 4, 1, 4)); // Sign fills from the top
		expect_write(4, 'hF96F);
		add_instr(encode_rrr(OP_SRA, 5, 1, 15));
		expect_write(5, 'hFFFF);
		add_instr(encode_rrr(OP_ROR, 6, 1, 4));
		expect_write(6, 'h096F);
		add_instr(encode_rrr(OP_ROR, 7, 1, 8));
		expect_write(7, 'hF096);
		add_instr(encode_rrr(OP_SRA, 8, 2, 3));
		expect_write(8, 'h0DE0);
		add_instr(encode_rrr(OP_ROR, 9, 8, 1));
		expect_write(9, 'h06F0);
		add_instr({OP_HLT, 12'h000});
		run_and_compare("shift");
	endtask

	task automatic test_memory();
		begin_program();
		add_instr(encode_imm8(OP_LLB, 1, 'h10)); // Base address
		expect_write(1, 'h0010);
		add_instr(encode_imm8(OP_LLB, 2, 'hCD));
		expect_write(2, 'h00CD);
		add_instr(encode_imm8(OP_LHB, 2, 'hAB));
		expect_write(2, 'hABCD);
		add_instr(encode_rrr(OP_SW, 2, 1, 0));   // 0x10 gets 0xABCD
		add_instr(encode_rrr(OP_SW, 1, 1, 3));   // 0x16 gets 0x0010
		add_instr(encode_rrr(OP_LW, 3, 1, 0));
		expect_write(3, 'hABCD);
		add_instr(encode_rrr(OP_ADD, 4, 3, 1));  // Load-use, one bubble
		expect_write(4, 'hABDD);
		add_instr(encode_rrr(OP_LW, 5, 1, 3));
		expect_write(5, 'h0010);
		add_instr(encode_rrr(OP_LW, 6, 1, 1));   // Never written, still zero
		expect_write(6, 'h0000);
		add_instr(encode_rrr(OP_SW, 4, 5, 1));   // Base comes from a load
		add_instr(encode_rrr(OP_LW, 7, 5, 1));
		expect_write(7, 'hABDD);
		add_instr(encode_rrr(OP_SUB, 8, 7, 4));
		expect_write(8, 'h0000);
		add_instr({OP_HLT, 12'h000});
		run_and_compare("memory");
	endtask

	task automatic test_branches();
		begin_program();
		add_instr(encode_imm8(OP_LLB, 1, 'h05));
		expect_write(1, 'h0005);
		add_instr(encode_imm8(OP_LLB, 2, 'h05));
		expect_write(2, 'h0005);
		add_instr(encode_rrr(OP_SUB, 3, 1, 2));  // Z set
		expect_write(3, 'h0000);
		add_instr(encode_b(COND_EQ, 2));         // Taken to index 6
		add_instr(encode_imm8(OP_LLB, 10, 'hAA));
		add_instr(encode_imm8(OP_LLB, 11, 'hBB));
		add_instr(encode_b(COND_NE, 1));         // Falls through
		add_instr(encode_imm8(OP_LLB, 4, 'h11));
		expect_write(4, 'h0011);
		add_instr(encode_rrr(OP_SUB, 5, 2, 4));  // N set
		expect_write(5, 'hFFF4);
		add_instr(encode_b(COND_LT, 2));         // Taken to index 12
		add_instr(encode_imm8(OP_LLB, 12, 'hCC));
		add_instr(encode_imm8(OP_LLB, 13, 'hDD));
		add_instr(encode_b(COND_GT, 1));         // Falls through
		add_instr(encode_rrr(OP_PCS, 6, 0, 0));  // Index 13, so 28
		expect_write(6, 'h001C);
		add_instr(encode_imm8(OP_LLB, 7, 'h24));
		expect_write(7, 'h0024);
		add_instr(encode_br(COND_UN, 7));        // Jumps to index 18
		add_instr(encode_imm8(OP_LLB, 14, 'hEE));
		add_instr(encode_imm8(OP_LLB, 15, 'hFF));
		add_instr(encode_imm8(OP_LLB, 8, 'h77));
		expect_write(8, 'h0077);
		add_instr({OP_HLT, 12'h000});
		run_and_compare("branch");
	endtask

	task automatic test_halt();
		begin_program();
		add_instr(encode_imm8(OP_LLB, 1, 'h01));
		expect_write(1, 'h0001);
		add_instr(encode_imm8(OP_LLB, 2, 'h02));
		expect_write(2, 'h0002);
		add_instr(encode_rrr(OP_ADD, 3, 1, 2));
		expect_write(3, 'h0003);
		add_instr({OP_HLT, 12'h000});
		add_instr(encode_imm8(OP_LLB, 4, 'h44)); // Must never retire
		add_instr(encode_imm8(OP_LLB, 5, 'h55));
		run_and_compare("halt");
	endtask

	// Budget of 200 cycles per test
	initial begin
		#(NUM_TESTS * 200 * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		int total;
		test_alu_forwarding();
		test_shifts();
		test_memory();
		test_branches();
		test_halt();
		total = errors + int'(uut.u_checker.fail_count);
		$display("Summary: %0d check errors, %0d assertion failures",
			errors, uut.u_checker.fail_count);
		if (total == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu.sv
cpu_checker.sv
cpu_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module cpu_tb -o cpu_sim \
	&& ./obj_dir/cpu_sim +verilator+error+limit+100 | tee /dev/stderr | grep -qx "TESTS PASSED" \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
